//--- dcache_macros.svh
// Cache geometry and datapath width macros for the data cache.

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Address and word widths in bits.
`define DC_ADDR_WIDTH   32
`define DC_DATA_WIDTH   32
`define WORD_SIZE       4

// Direct mapped with 16 sets of 16-byte lines.
`define DC_LINE_SIZE    16
`define DC_NUM_SETS     16
`define DC_INDEX_WIDTH  4
`define DC_OFFSET_WIDTH 4

`define DC_TAG_WIDTH    (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

`endif

//--- dcache_pkg.sv
// Data cache package with address field, data, byte select and LSU function types.

`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    // Address fields.
    typedef logic [`DC_TAG_WIDTH-1:0]    dc_tag_t;
    typedef logic [`DC_INDEX_WIDTH-1:0]  dc_index_t;
    typedef logic [`DC_OFFSET_WIDTH-1:0] dc_offset_t;

    // A word and a whole cache line.
    typedef logic [`DC_DATA_WIDTH-1:0]   dc_data_t;
    typedef logic [`DC_LINE_SIZE*8-1:0]  dc_line_t;

    // One enable per byte of a word, and one per byte of a line.
    typedef logic [`WORD_SIZE-1:0]       dc_byte_sel_t;
    typedef logic [`DC_LINE_SIZE-1:0]    dc_line_be_t;

    // Load and store functions issued by the LSU.
    typedef enum logic [2:0] {
        LSU_FUNC_LB,
        LSU_FUNC_LH,
        LSU_FUNC_LW,
        LSU_FUNC_LBU,
        LSU_FUNC_LHU,
        LSU_FUNC_SB,
        LSU_FUNC_SH,
        LSU_FUNC_SW
    } lsu_func_t;

endpackage

`default_nettype wire

//--- dcache_if.sv
// Request pipeline interface and the tag and data array access interfaces.

`default_nettype none
`timescale 1ns/1ns

// Registered request from the request stage to both arrays and the combine stage.
interface dc_pipe_if
    import dcache_pkg::*;
();

    logic         en;
    logic         wr_en;
    logic         fill;
    lsu_func_t    func;
    dc_tag_t      tag;
    dc_index_t    index;
    dc_offset_t   offset;
    dc_byte_sel_t byte_sel;
    dc_data_t     data;
    dc_line_t     fill_data;

    modport src (
        output en, wr_en, fill, func, tag, index, offset, byte_sel, data, fill_data
    );

    modport sink (
        input  en, wr_en, fill, func, tag, index, offset, byte_sel, data, fill_data
    );

endinterface

// Tag array read result and write port.
interface dc_tag_if
    import dcache_pkg::*;
();

    logic      rd_valid;
    logic      rd_dirty;
    dc_tag_t   rd_tag;

    logic      wr_en;
    dc_index_t wr_index;
    logic      wr_valid;
    logic      wr_dirty;
    dc_tag_t   wr_tag;

    modport ram (
        output rd_valid, rd_dirty, rd_tag,
        input  wr_en, wr_index, wr_valid, wr_dirty, wr_tag
    );

    modport ctrl (
        input  rd_valid, rd_dirty, rd_tag,
        output wr_en, wr_index, wr_valid, wr_dirty, wr_tag
    );

endinterface

// Data array read result and byte-lane write port.
interface dc_data_if
    import dcache_pkg::*;
();

    dc_line_t    rd_line;

    logic        wr_en;
    dc_index_t   wr_index;
    dc_line_be_t wr_be;
    dc_line_t    wr_line;

    modport ram (
        output rd_line,
        input  wr_en, wr_index, wr_be, wr_line
    );

    modport ctrl (
        input  rd_line,
        output wr_en, wr_index, wr_be, wr_line
    );

endinterface

`default_nettype wire

//--- dcache_d0.sv
// Request register stage with byte select decode from the LSU function.

`default_nettype none
`timescale 1ns/1ns

`include "dcache_macros.svh"

module dcache_d0
    import dcache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       n_rst,

    input  wire logic       i_en,
    input  wire logic       i_wr_en,
    input  wire logic       i_fill,
    input  lsu_func_t       i_lsu_func,
    input  dc_tag_t         i_tag,
    input  dc_index_t       i_index,
    input  dc_offset_t      i_offset,
    input  dc_data_t        i_data,
    input  dc_line_t        i_fill_data,

    dc_pipe_if.src          pipe
);

    dc_byte_sel_t byte_sel;

    // Byte, halfword or word lanes, aligned to lane 0 of the word.
    always_comb begin
        case (i_lsu_func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: begin
                byte_sel = {{(`WORD_SIZE-1){1'b0}}, 1'b1};
            end
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: begin
                byte_sel = {{(`WORD_SIZE/2){1'b0}}, {(`WORD_SIZE/2){1'b1}}};
            end
            default: begin
                byte_sel = {(`WORD_SIZE){1'b1}};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            pipe.en <= 1'b0;
        end else begin
            pipe.en <= i_en;
        end
    end

    always_ff @(posedge clk) begin
        pipe.wr_en     <= i_wr_en;
        pipe.fill      <= i_fill;
        pipe.func      <= i_lsu_func;
        pipe.tag       <= i_tag;
        pipe.index     <= i_index;
        pipe.offset    <= i_offset;
        pipe.byte_sel  <= byte_sel;
        pipe.data      <= i_data;
        pipe.fill_data <= i_fill_data;
    end

    // Halfwords must sit on an even offset and words on a multiple of four.
    assert property (@(posedge clk) disable iff (~n_rst)
        (i_en && !i_fill) |->
            !((byte_sel[1] && i_offset[0]) || (byte_sel[2] && (i_offset[1:0] != 2'b00))))
        else $error("misaligned access func=%s offset=%0h", i_lsu_func.name(), i_offset);

endmodule

`default_nettype wire

//--- dcache_tag_ram.sv
// Tag, valid and dirty array with a write-first synchronous read and valid clear.

`default_nettype none
`timescale 1ns/1ns

`include "dcache_macros.svh"

module dcache_tag_ram
    import dcache_pkg::*;
(
    input  wire logic clk,
    input  wire logic n_rst,

    dc_pipe_if.sink   pipe,
    dc_tag_if.ram     tag
);

    dc_tag_t                 tag_mem [`DC_NUM_SETS];
    logic                    dirty_mem [`DC_NUM_SETS];
    logic [`DC_NUM_SETS-1:0] valid_q;

    logic                    clr_busy;
    dc_index_t               clr_idx;

    // The valid bits are walked to zero one set per cycle after reset.
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == dc_index_t'(`DC_NUM_SETS - 1)) begin
                clr_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_busy) begin
            valid_q[clr_idx] <= 1'b0;
        end else if (tag.wr_en) begin
            valid_q[tag.wr_index] <= tag.wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tag.wr_en) begin
            tag_mem[tag.wr_index]   <= tag.wr_tag;
            dirty_mem[tag.wr_index] <= tag.wr_dirty;
        end
    end

    // A write to the set being read wins, so a younger request sees it.
    always_ff @(posedge clk) begin
        if (pipe.en) begin
            if (tag.wr_en && (tag.wr_index == pipe.index)) begin
                tag.rd_valid <= tag.wr_valid;
                tag.rd_dirty <= tag.wr_dirty;
                tag.rd_tag   <= tag.wr_tag;
            end else begin
                tag.rd_valid <= valid_q[pipe.index];
                tag.rd_dirty <= dirty_mem[pipe.index];
                tag.rd_tag   <= tag_mem[pipe.index];
            end
        end
    end

    assert property (@(posedge clk) disable iff (~n_rst) clr_busy |-> !tag.wr_en)
        else $error("tag array written while valid clear is running");

endmodule

`default_nettype wire

//--- dcache_data_ram.sv
// Line data array with byte-lane writes and a write-first synchronous read.

`default_nettype none
`timescale 1ns/1ns

`include "dcache_macros.svh"

module dcache_data_ram
    import dcache_pkg::*;
(
    input  wire logic clk,

    dc_pipe_if.sink   pipe,
    dc_data_if.ram    data
);

    dc_line_t data_mem [`DC_NUM_SETS];

    logic     fwd_hit;

    // The set being read is also the set written this cycle.
    assign fwd_hit = data.wr_en && (data.wr_index == pipe.index);

    always_ff @(posedge clk) begin
        if (data.wr_en) begin
            for (int i = 0; i < `DC_LINE_SIZE; i++) begin
                if (data.wr_be[i]) begin
                    data_mem[data.wr_index][i*8 +: 8] <= data.wr_line[i*8 +: 8];
                end
            end
        end
    end

    // Written lanes come from the write port, the rest from the array.
    always_ff @(posedge clk) begin
        if (pipe.en) begin
            for (int i = 0; i < `DC_LINE_SIZE; i++) begin
                if (fwd_hit && data.wr_be[i]) begin
                    data.rd_line[i*8 +: 8] <= data.wr_line[i*8 +: 8];
                end else begin
                    data.rd_line[i*8 +: 8] <= data_mem[pipe.index][i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_d2.sv
// Combine stage with hit detection, load extension, store merge, fill write and response.

`default_nettype none
`timescale 1ns/1ns

`include "dcache_macros.svh"

module dcache_d2
    import dcache_pkg::*;
(
    input  wire logic clk,
    input  wire logic n_rst,

    dc_pipe_if.sink   pipe,
    dc_tag_if.ctrl    tag,
    dc_data_if.ctrl   data,

    output logic      o_valid,
    output logic      o_hit,
    output dc_data_t  o_data,
    output logic      o_victim_dirty,
    output dc_tag_t   o_victim_tag
);

    logic         s2_en;
    logic         s2_wr_en;
    logic         s2_fill;
    lsu_func_t    s2_func;
    dc_tag_t      s2_tag;
    dc_index_t    s2_index;
    dc_offset_t   s2_offset;
    dc_byte_sel_t s2_byte_sel;
    dc_data_t     s2_data;
    dc_line_t     s2_fill_data;

    logic         hit;
    logic         fill_wr;
    logic         store_wr;
    dc_data_t     rd_word;
    dc_data_t     rd_shift;
    dc_data_t     ld_data;
    dc_byte_sel_t word_be;
    dc_data_t     st_word;

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            s2_en <= 1'b0;
        end else begin
            s2_en <= pipe.en;
        end
    end

    // Request fields line up with the array reads issued at the same edge.
    always_ff @(posedge clk) begin
        s2_wr_en     <= pipe.wr_en;
        s2_fill      <= pipe.fill;
        s2_func      <= pipe.func;
        s2_tag       <= pipe.tag;
        s2_index     <= pipe.index;
        s2_offset    <= pipe.offset;
        s2_byte_sel  <= pipe.byte_sel;
        s2_data      <= pipe.data;
        s2_fill_data <= pipe.fill_data;
    end

    assign hit      = tag.rd_valid && (tag.rd_tag == s2_tag);
    assign fill_wr  = s2_en && s2_fill;
    assign store_wr = s2_en && s2_wr_en && !s2_fill && hit;

    // Pick the word, then move the addressed byte or halfword down to bit 0.
    assign rd_word  = data.rd_line[s2_offset[`DC_OFFSET_WIDTH-1:2]*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];
    assign rd_shift = rd_word >> {s2_offset[1:0], 3'b000};

    always_comb begin
        case (s2_func)
            LSU_FUNC_LB:  ld_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
            LSU_FUNC_LH:  ld_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
            LSU_FUNC_LW:  ld_data = rd_word;
            LSU_FUNC_LBU: ld_data = {24'b0, rd_shift[7:0]};
            LSU_FUNC_LHU: ld_data = {16'b0, rd_shift[15:0]};
            default:      ld_data = '0;
        endcase
    end

    // Store lanes and data are shifted into place within the word.
    assign word_be = dc_byte_sel_t'(s2_byte_sel << s2_offset[1:0]);
    assign st_word = s2_data << {s2_offset[1:0], 3'b000};

    assign tag.wr_en    = fill_wr || store_wr;
    assign tag.wr_index = s2_index;
    assign tag.wr_valid = 1'b1;
    assign tag.wr_dirty = store_wr;
    assign tag.wr_tag   = s2_tag;

    assign data.wr_en    = fill_wr || store_wr;
    assign data.wr_index = s2_index;
    assign data.wr_be    = fill_wr ? {(`DC_LINE_SIZE){1'b1}}
                                   : dc_line_be_t'(dc_line_be_t'(word_be)
                                       << {s2_offset[`DC_OFFSET_WIDTH-1:2], 2'b00});
    assign data.wr_line  = fill_wr ? s2_fill_data : {(`DC_LINE_SIZE/`WORD_SIZE){st_word}};

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= s2_en && !s2_fill;
        end
    end

    // Victim status only shows on a miss against a valid line.
    always_ff @(posedge clk) begin
        o_hit          <= hit;
        o_data         <= (hit && !s2_wr_en) ? ld_data : '0;
        o_victim_dirty <= !hit && tag.rd_valid && tag.rd_dirty;
        o_victim_tag   <= (!hit && tag.rd_valid) ? tag.rd_tag : '0;
    end

    assert property (@(posedge clk) disable iff (~n_rst) pipe.en |-> !(pipe.fill && pipe.wr_en))
        else $error("request with both fill and store set");

endmodule

`default_nettype wire

//--- dcache.sv
// Data cache top level with address split and stage wiring.

`default_nettype none
`timescale 1ns/1ns

`include "dcache_macros.svh"

module dcache
    import dcache_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      n_rst,

    input  wire logic                      i_en,
    input  wire logic                      i_wr_en,
    input  wire logic                      i_fill,
    input  lsu_func_t                      i_lsu_func,
    input  wire logic [`DC_ADDR_WIDTH-1:0] i_addr,
    input  dc_data_t                       i_data,
    input  dc_line_t                       i_fill_data,

    output logic                           o_valid,
    output logic                           o_hit,
    output dc_data_t                       o_data,
    output logic                           o_victim_dirty,
    output dc_tag_t                        o_victim_tag
);

    dc_tag_t    addr_tag;
    dc_index_t  addr_index;
    dc_offset_t addr_offset;

    // Tag on top, then set index, then byte offset in the line.
    assign addr_tag    = i_addr[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign addr_index  = i_addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
    assign addr_offset = i_addr[`DC_OFFSET_WIDTH-1:0];

    dc_pipe_if pipe_if ();
    dc_tag_if  tag_if ();
    dc_data_if data_if ();

    dcache_d0 dcache_d0_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_en        (i_en),
        .i_wr_en     (i_wr_en),
        .i_fill      (i_fill),
        .i_lsu_func  (i_lsu_func),
        .i_tag       (addr_tag),
        .i_index     (addr_index),
        .i_offset    (addr_offset),
        .i_data      (i_data),
        .i_fill_data (i_fill_data),
        .pipe        (pipe_if.src)
    );

    dcache_tag_ram dcache_tag_ram_i (
        .clk   (clk),
        .n_rst (n_rst),
        .pipe  (pipe_if.sink),
        .tag   (tag_if.ram)
    );

    dcache_data_ram dcache_data_ram_i (
        .clk  (clk),
        .pipe (pipe_if.sink),
        .data (data_if.ram)
    );

    dcache_d2 dcache_d2_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .pipe           (pipe_if.sink),
        .tag            (tag_if.ctrl),
        .data           (data_if.ctrl),
        .o_valid        (o_valid),
        .o_hit          (o_hit),
        .o_data         (o_data),
        .o_victim_dirty (o_victim_dirty),
        .o_victim_tag   (o_victim_tag)
    );

endmodule

`default_nettype wire

//--- dcache_tb.sv
// Table-driven testbench for the data cache pipeline with response queue and checks.

`default_nettype none
`timescale 1ns/1ns

`include "dcache_macros.svh"

module dcache_tb
    import dcache_pkg::*;
();

    typedef struct packed {
        logic                      wr;
        logic                      fill;
        lsu_func_t                 func;
        logic [`DC_ADDR_WIDTH-1:0] addr;
        logic [31:0]               data;
        logic [127:0]              line;
        logic                      hit;
        logic [31:0]               rdata;
        logic                      vdirty;
        logic [`DC_TAG_WIDTH-1:0]  vtag;
    } entry_t;

    localparam logic [23:0] tag_a = 24'h00a1b2;
    localparam logic [23:0] tag_b = 24'h00c3d4;
    localparam logic [23:0] tag_c = 24'h0055ee;

    logic clk;
    logic n_rst;
    logic i_en;
    logic i_wr_en;
    logic i_fill;
    lsu_func_t i_lsu_func;
    logic [31:0] i_addr;
    dc_data_t i_data;
    dc_line_t i_fill_data;
    logic o_valid;
    logic o_hit;
    dc_data_t o_data;
    logic o_victim_dirty;
    dc_tag_t o_victim_tag;

    entry_t table_q[$];
    entry_t exp_q[$];
    int idx_q[$];
    logic [31:0] fw [12];
    logic [31:0] lcg_state;
    int pass_cnt;
    int fail_cnt;
    int wait_cycles;
    bit entry_ok;

    dcache dcache_i (
        .clk (clk), .n_rst (n_rst), .i_en (i_en), .i_wr_en (i_wr_en), .i_fill (i_fill),
        .i_lsu_func (i_lsu_func), .i_addr (i_addr), .i_data (i_data),
        .i_fill_data (i_fill_data), .o_valid (o_valid), .o_hit (o_hit), .o_data (o_data),
        .o_victim_dirty (o_victim_dirty), .o_victim_tag (o_victim_tag)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] sext8(input logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] h);
        return {{16{h[15]}}, h};
    endfunction

    function automatic logic [31:0] addr_of(input logic [23:0] t, input logic [3:0] set,
                                            input logic [3:0] off);
        return {t, set, off};
    endfunction

    task automatic add_entry(input logic wr, input logic fill, input lsu_func_t func,
                             input logic [31:0] addr, input logic [31:0] data,
                             input logic [127:0] line, input logic hit,
                             input logic [31:0] rdata, input logic vd, input logic [23:0] vt);
        entry_t e;
        e.wr = wr;
        e.fill = fill;
        e.func = func;
        e.addr = addr;
        e.data = data;
        e.line = line;
        e.hit = hit;
        e.rdata = rdata;
        e.vdirty = vd;
        e.vtag = vt;
        table_q.push_back(e);
    endtask

    task automatic add_load(input lsu_func_t func, input logic [23:0] t, input logic [3:0] set,
                            input logic [3:0] off, input logic hit, input logic [31:0] rdata,
                            input logic vd, input logic [23:0] vt);
        add_entry(1'b0, 1'b0, func, addr_of(t, set, off), 32'h0, 128'h0, hit, rdata, vd, vt);
    endtask

    task automatic add_store(input lsu_func_t func, input logic [23:0] t, input logic [3:0] set,
                             input logic [3:0] off, input logic [31:0] data, input logic hit,
                             input logic vd, input logic [23:0] vt);
        add_entry(1'b1, 1'b0, func, addr_of(t, set, off), data, 128'h0, hit, 32'h0, vd, vt);
    endtask

    task automatic add_fill(input logic [23:0] t, input logic [3:0] set, input int first);
        add_entry(1'b0, 1'b1, LSU_FUNC_LW, addr_of(t, set, 4'h0), 32'h0,
                  {fw[first+3], fw[first+2], fw[first+1], fw[first]}, 1'b0, 32'h0, 1'b0, 24'h0);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: expected %h, got %h", name, exp, got);
            entry_ok = 1'b0;
        end
    endtask

    // Responses come back in order, so the queue head is always the next one due.
    always @(negedge clk) begin
        entry_t e;
        lsu_func_t f;
        int n;
        if (n_rst) begin
            if (o_valid) begin
                wait_cycles = 0;
                if (exp_q.size() == 0) begin
                    $display("response arrived with no request outstanding");
                    fail_cnt++;
                end else begin
                    e = exp_q.pop_front();
                    n = idx_q.pop_front();
                    f = e.func;
                    entry_ok = 1'b1;
                    check_field("o_hit", o_hit, e.hit);
                    check_field("o_data", o_data, e.rdata);
                    check_field("o_victim_dirty", o_victim_dirty, e.vdirty);
                    check_field("o_victim_tag", o_victim_tag, e.vtag);
                    if (entry_ok) pass_cnt++;
                    else fail_cnt++;
                    $display("entry %0d %s addr %h %s", n, f.name(), e.addr,
                             entry_ok ? "ok" : "failed");
                end
            end else if (exp_q.size() != 0) begin
                wait_cycles++;
                if (wait_cycles > 6) begin
                    $display("entry %0d got no response within 6 cycles", idx_q[0]);
                    void'(exp_q.pop_front());
                    void'(idx_q.pop_front());
                    fail_cnt++;
                    wait_cycles = 0;
                end
            end
        end
    end

    initial begin
        int drain_cycles;
        clk = 1'b0;
        n_rst = 1'b0;
        i_en = 1'b0;
        i_wr_en = 1'b0;
        i_fill = 1'b0;
        i_lsu_func = LSU_FUNC_LW;
        i_addr = '0;
        i_data = '0;
        i_fill_data = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        wait_cycles = 0;
        lcg_state = 32'h590d;
        for (int i = 0; i < 12; i++) begin
            lcg_state = lcg_next(lcg_state);
            fw[i] = lcg_state;
        end

        // Cold sets miss with no victim.
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd0, 1'b0, 32'h0, 1'b0, 24'h0);
        add_load(LSU_FUNC_LBU, tag_c, 4'd7, 4'd5, 1'b0, 32'h0, 1'b0, 24'h0);
        // Fill set 3 and read every word.
        add_fill(tag_a, 4'd3, 0);
        for (int w = 0; w < 4; w++) begin
            add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'(w * 4), 1'b1, fw[w], 1'b0, 24'h0);
        end
        for (int b = 0; b < 4; b++) begin
            add_load(LSU_FUNC_LB, tag_a, 4'd3, 4'(4 + b), 1'b1, sext8(fw[1][b*8 +: 8]), 1'b0, 24'h0);
            add_load(LSU_FUNC_LBU, tag_a, 4'd3, 4'(4 + b), 1'b1, {24'h0, fw[1][b*8 +: 8]},
                     1'b0, 24'h0);
        end
        for (int h = 0; h < 2; h++) begin
            add_load(LSU_FUNC_LH, tag_a, 4'd3, 4'(4 + h * 2), 1'b1, sext16(fw[1][h*16 +: 16]),
                     1'b0, 24'h0);
            add_load(LSU_FUNC_LHU, tag_a, 4'd3, 4'(4 + h * 2), 1'b1, {16'h0, fw[1][h*16 +: 16]},
                     1'b0, 24'h0);
        end
        // Store hits followed at once by loads of the same set.
        add_store(LSU_FUNC_SW, tag_a, 4'd3, 4'd8, 32'h80ff7f01, 1'b1, 1'b0, 24'h0);
        add_load(LSU_FUNC_LB, tag_a, 4'd3, 4'd8, 1'b1, 32'h00000001, 1'b0, 24'h0);
        add_load(LSU_FUNC_LB, tag_a, 4'd3, 4'd9, 1'b1, 32'h0000007f, 1'b0, 24'h0);
        add_load(LSU_FUNC_LB, tag_a, 4'd3, 4'd10, 1'b1, 32'hffffffff, 1'b0, 24'h0);
        add_load(LSU_FUNC_LBU, tag_a, 4'd3, 4'd11, 1'b1, 32'h00000080, 1'b0, 24'h0);
        add_load(LSU_FUNC_LH, tag_a, 4'd3, 4'd10, 1'b1, 32'hffff80ff, 1'b0, 24'h0);
        add_load(LSU_FUNC_LHU, tag_a, 4'd3, 4'd8, 1'b1, 32'h00007f01, 1'b0, 24'h0);
        add_store(LSU_FUNC_SB, tag_a, 4'd3, 4'd13, 32'h123456c3, 1'b1, 1'b0, 24'h0);
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd12, 1'b1, {fw[3][31:16], 8'hc3, fw[3][7:0]},
                 1'b0, 24'h0);
        add_store(LSU_FUNC_SH, tag_a, 4'd3, 4'd2, 32'habcd9e5a, 1'b1, 1'b0, 24'h0);
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd0, 1'b1, {16'h9e5a, fw[0][15:0]}, 1'b0, 24'h0);
        add_store(LSU_FUNC_SB, tag_a, 4'd3, 4'd0, 32'h00000011, 1'b1, 1'b0, 24'h0);
        add_store(LSU_FUNC_SB, tag_a, 4'd3, 4'd1, 32'h00000022, 1'b1, 1'b0, 24'h0);
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd0, 1'b1, 32'h9e5a2211, 1'b0, 24'h0);
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd4, 1'b1, fw[1], 1'b0, 24'h0);
        // Store miss leaves the dirty line alone and reports it as victim.
        add_store(LSU_FUNC_SW, tag_b, 4'd3, 4'd0, 32'hdeadbeef, 1'b0, 1'b1, tag_a);
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd0, 1'b1, 32'h9e5a2211, 1'b0, 24'h0);
        add_load(LSU_FUNC_LW, tag_b, 4'd3, 4'd4, 1'b0, 32'h0, 1'b1, tag_a);
        add_fill(tag_c, 4'd7, 8);
        add_load(LSU_FUNC_LW, tag_a, 4'd7, 4'd0, 1'b0, 32'h0, 1'b0, tag_c);
        add_load(LSU_FUNC_LW, tag_c, 4'd7, 4'd12, 1'b1, fw[11], 1'b0, 24'h0);
        // Refill of the dirty set with a new tag.
        add_fill(tag_b, 4'd3, 4);
        add_load(LSU_FUNC_LW, tag_a, 4'd3, 4'd0, 1'b0, 32'h0, 1'b0, tag_b);
        add_load(LSU_FUNC_LW, tag_b, 4'd3, 4'd0, 1'b1, fw[4], 1'b0, 24'h0);
        add_load(LSU_FUNC_LW, tag_b, 4'd3, 4'd12, 1'b1, fw[7], 1'b0, 24'h0);
        add_load(LSU_FUNC_LH, tag_b, 4'd3, 4'd6, 1'b1, sext16(fw[5][31:16]), 1'b0, 24'h0);

        repeat (4) @(posedge clk);
        #1 n_rst = 1'b1;
        repeat (20) @(posedge clk);

        foreach (table_q[i]) begin
            @(posedge clk);
            #1;
            i_en = 1'b1;
            i_wr_en = table_q[i].wr;
            i_fill = table_q[i].fill;
            i_lsu_func = table_q[i].func;
            i_addr = table_q[i].addr;
            i_data = table_q[i].data;
            i_fill_data = table_q[i].line;
            if (table_q[i].fill) begin
                $display("entry %0d fill addr %h issued", i, table_q[i].addr);
            end else begin
                exp_q.push_back(table_q[i]);
                idx_q.push_back(i);
            end
        end
        @(posedge clk);
        #1 i_en = 1'b0;

        drain_cycles = 0;
        while (exp_q.size() != 0 && drain_cycles < 10) begin
            @(posedge clk);
            drain_cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("responses still outstanding after the drain timeout");
            fail_cnt++;
        end
        repeat (2) @(posedge clk);
        $display("responses checked: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
dcache_pkg.sv
dcache_if.sv
dcache_d0.sv
dcache_tag_ram.sv
dcache_data_ram.sv
dcache_d2.sv
dcache.sv
dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f vlog.f -o dcache_sim \
    && ./obj_dir/dcache_sim | tee sim.log \
    || echo "build or simulation step failed"

grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
